// ==== common/dcache_pkg.sv ====
// dcache_pkg: shared widths, cache geometry, backing memory depth and controller states
package dcache_pkg;

  // byte address and data word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTE_W = 8;

  // one enable per byte of a word
  localparam int BE_W = DATA_W / BYTE_W;

  // line geometry
  localparam int LINE_WORDS = 4;
  localparam int LINE_W = LINE_WORDS * DATA_W;

  // address split, low to high: byte in word, word in line, set index, tag
  localparam int WORD_OFF_BITS = 2;
  localparam int LINE_OFF_BITS = 2;
  localparam int INDEX_BITS = 4;
  localparam int TAG_BITS = ADDR_W - INDEX_BITS - LINE_OFF_BITS - WORD_OFF_BITS;

  // direct mapped, one line per set
  localparam int NUM_SETS = 1 << INDEX_BITS;

  // backing memory depth in words, addresses wrap at this size
  localparam int MEM_WORDS = 1024;
  localparam int MEM_IDX_BITS = $clog2(MEM_WORDS);

  // cycles from line request to line ready, run cycles only
  localparam int L2_MISS_PENALTY = 4;

  // controller states
  // idle: ready for a request, array read launched on accept
  // lookup: tag compare, decides hit, miss or store
  // miss_wait: line requested, waiting for the backing memory
  // fill: line written into the array, load answered
  // store_wait: write sent through, waiting for done
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_MISS_WAIT,
    ST_FILL,
    ST_STORE_WAIT
  } cache_state_e;

endpackage

// ==== dcache/dcache_array.sv ====
// dcache_array: tag, valid and line storage of the direct-mapped L1 with registered reads
`timescale 1ns/1ps

module dcache_array (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  rd_en_i,
  input  logic [dcache_pkg::INDEX_BITS-1:0]     index_i,
  input  logic                                  fill_en_i,
  input  logic [dcache_pkg::TAG_BITS-1:0]       fill_tag_i,
  input  logic [dcache_pkg::LINE_W-1:0]         fill_line_i,
  input  logic                                  upd_en_i,
  input  logic [dcache_pkg::LINE_OFF_BITS-1:0]  upd_word_i,
  input  logic [dcache_pkg::DATA_W-1:0]         upd_data_i,
  input  logic [dcache_pkg::BE_W-1:0]           upd_be_i,
  output logic [dcache_pkg::TAG_BITS-1:0]       rd_tag_o,
  output logic                                  rd_valid_o,
  output logic [dcache_pkg::LINE_W-1:0]         rd_line_o
);
  import dcache_pkg::*;

  logic [TAG_BITS-1:0]  tag_q [NUM_SETS];
  logic [NUM_SETS-1:0]  valid_q;
  logic [LINE_W-1:0]    line_q [NUM_SETS];
  logic [LINE_W-1:0]    merged_line;

  // store hit, new bytes laid over the cached word
  always_comb
  begin
    merged_line = line_q[index_i];
    for (int b = 0; b < BE_W; b++)
    begin
      if (upd_be_i[b])
        merged_line[upd_word_i*DATA_W + b*BYTE_W +: BYTE_W] = upd_data_i[b*BYTE_W +: BYTE_W];
    end
  end

  // only the valid bits need clearing
  always_ff @(posedge clk)
  begin
    if (reset)
      valid_q <= '0;
    else if (fill_en_i)
      valid_q[index_i] <= 1'b1;
  end

  // fill replaces the whole line, update touches one word
  always_ff @(posedge clk)
  begin
    if (fill_en_i)
    begin
      tag_q[index_i] <= fill_tag_i;
      line_q[index_i] <= fill_line_i;
    end
    else if (upd_en_i)
      line_q[index_i] <= merged_line;
  end

  // registered read port
  always_ff @(posedge clk)
  begin
    if (reset)
      rd_valid_o <= 1'b0;
    else if (rd_en_i)
      rd_valid_o <= valid_q[index_i];
  end

  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      rd_tag_o <= tag_q[index_i];
      rd_line_o <= line_q[index_i];
    end
  end

endmodule

// ==== dcache/dcache_ctrl.sv ====
// dcache_ctrl: L1 data cache controller, hit check, miss refill, write-through stores
`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                                  clk,
  input  logic                                  reset,

  // cpu request and response
  input  logic                                  req_valid_i,
  input  logic                                  req_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0]         req_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0]         req_wdata_i,
  input  logic [dcache_pkg::BE_W-1:0]           req_be_i,
  output logic                                  req_ready_o,
  output logic                                  resp_valid_o,
  output logic [dcache_pkg::DATA_W-1:0]         resp_rdata_o,

  // tag and line array
  output logic                                  arr_rd_en_o,
  output logic [dcache_pkg::INDEX_BITS-1:0]     arr_index_o,
  output logic                                  arr_fill_en_o,
  output logic [dcache_pkg::TAG_BITS-1:0]       arr_fill_tag_o,
  output logic [dcache_pkg::LINE_W-1:0]         arr_fill_line_o,
  output logic                                  arr_upd_en_o,
  output logic [dcache_pkg::LINE_OFF_BITS-1:0]  arr_upd_word_o,
  output logic [dcache_pkg::DATA_W-1:0]         arr_upd_data_o,
  output logic [dcache_pkg::BE_W-1:0]           arr_upd_be_o,
  input  logic [dcache_pkg::TAG_BITS-1:0]       arr_rd_tag_i,
  input  logic                                  arr_rd_valid_i,
  input  logic [dcache_pkg::LINE_W-1:0]         arr_rd_line_i,

  // backing memory, line reads and word writes
  output logic                                  mem_re_o,
  output logic [dcache_pkg::ADDR_W-1:0]         mem_addr_o,
  output logic                                  mem_we_o,
  output logic [dcache_pkg::ADDR_W-1:0]         mem_wr_addr_o,
  output logic [dcache_pkg::DATA_W-1:0]         mem_wr_data_o,
  output logic [dcache_pkg::BE_W-1:0]           mem_wr_byte_en_o,
  input  logic                                  mem_data_ready_i,
  input  logic [dcache_pkg::LINE_W-1:0]         mem_data_i,
  input  logic                                  mem_wr_done_i
);
  import dcache_pkg::*;

  cache_state_e               state_q;
  cache_state_e               state_d;

  // latched request
  logic [ADDR_W-1:0]          addr_q;
  logic                       we_q;
  logic [DATA_W-1:0]          wdata_q;
  logic [BE_W-1:0]            be_q;

  // response and one-cycle command pulses
  logic                       hit_rsp_q;
  logic [DATA_W-1:0]          rdata_q;
  logic                       mem_re_q;
  logic                       mem_we_q;
  logic                       upd_en_q;

  logic                       accept;
  logic                       lookup_hit;
  logic                       fill;
  logic [TAG_BITS-1:0]        req_tag;
  logic [INDEX_BITS-1:0]      req_index;
  logic [LINE_OFF_BITS-1:0]   req_word;

  // word out of a line by word offset
  function automatic logic [DATA_W-1:0] pick_word(input logic [LINE_W-1:0] line,
                                                  input logic [LINE_OFF_BITS-1:0] word);
    pick_word = line[word*DATA_W +: DATA_W];
  endfunction

  assign accept = req_valid_i && (state_q == ST_IDLE);

  // fields of the held address
  assign req_tag = addr_q[ADDR_W-1 -: TAG_BITS];
  assign req_index = addr_q[WORD_OFF_BITS+LINE_OFF_BITS +: INDEX_BITS];
  assign req_word = addr_q[WORD_OFF_BITS +: LINE_OFF_BITS];

  // array output is for the held request while in lookup
  assign lookup_hit = arr_rd_valid_i && (arr_rd_tag_i == req_tag);

  // line arrives, written into the set at the same edge
  assign fill = (state_q == ST_MISS_WAIT) && mem_data_ready_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (req_valid_i)
          state_d = ST_LOOKUP;
      ST_LOOKUP:
        if (we_q)
          state_d = ST_STORE_WAIT;
        else if (lookup_hit)
          state_d = ST_IDLE;
        else
          state_d = ST_MISS_WAIT;
      ST_MISS_WAIT:
        if (mem_data_ready_i)
          state_d = ST_FILL;
      // answer the load, array already holds the line
      ST_FILL:
        state_d = ST_IDLE;
      ST_STORE_WAIT:
        if (mem_wr_done_i)
          state_d = ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= ST_IDLE;
      hit_rsp_q <= 1'b0;
      mem_re_q <= 1'b0;
      mem_we_q <= 1'b0;
      upd_en_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // load hit answers the cycle after lookup
      hit_rsp_q <= (state_q == ST_LOOKUP) && !we_q && lookup_hit;
      // load miss asks for the whole line
      mem_re_q <= (state_q == ST_LOOKUP) && !we_q && !lookup_hit;
      // every store goes through, the cached word only on a hit
      mem_we_q <= (state_q == ST_LOOKUP) && we_q;
      upd_en_q <= (state_q == ST_LOOKUP) && we_q && lookup_hit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q <= req_addr_i;
      we_q <= req_we_i;
      wdata_q <= req_wdata_i;
      be_q <= req_be_i;
    end
    if ((state_q == ST_LOOKUP) && !we_q && lookup_hit)
      rdata_q <= pick_word(arr_rd_line_i, req_word);
    else if (fill)
      rdata_q <= pick_word(mem_data_i, req_word);
  end

  // cpu side
  assign req_ready_o = (state_q == ST_IDLE);
  assign resp_valid_o = hit_rsp_q || (state_q == ST_FILL) ||
                        ((state_q == ST_STORE_WAIT) && mem_wr_done_i);
  assign resp_rdata_o = rdata_q;

  // read launched with the incoming index, later accesses use the held one
  assign arr_rd_en_o = accept;
  assign arr_index_o = (state_q == ST_IDLE) ?
                       req_addr_i[WORD_OFF_BITS+LINE_OFF_BITS +: INDEX_BITS] : req_index;
  assign arr_fill_en_o = fill;
  assign arr_fill_tag_o = req_tag;
  assign arr_fill_line_o = mem_data_i;
  assign arr_upd_en_o = upd_en_q;
  assign arr_upd_word_o = req_word;
  assign arr_upd_data_o = wdata_q;
  assign arr_upd_be_o = be_q;

  // line address for refill, word address for stores
  assign mem_re_o = mem_re_q;
  assign mem_addr_o = {addr_q[ADDR_W-1:WORD_OFF_BITS+LINE_OFF_BITS],
                       {(WORD_OFF_BITS+LINE_OFF_BITS){1'b0}}};
  assign mem_we_o = mem_we_q;
  assign mem_wr_addr_o = {addr_q[ADDR_W-1:WORD_OFF_BITS], {WORD_OFF_BITS{1'b0}}};
  assign mem_wr_data_o = wdata_q;
  assign mem_wr_byte_en_o = be_q;

endmodule

// ==== hdl/l2_backing_mem.sv ====
// l2_backing_mem: word-array data memory with delayed line reads and byte-enabled word writes
`timescale 1ns/1ps

module l2_backing_mem #(
  parameter int MISS_PENALTY = dcache_pkg::L2_MISS_PENALTY
) (
  input  logic                           clk,
  input  logic                           reset,
  // low while the core is halted, freezes the read countdown
  input  logic                           run_i,

  // line read port
  input  logic                           mem_re_i,
  input  logic [dcache_pkg::ADDR_W-1:0]  mem_addr_i,
  output logic [dcache_pkg::LINE_W-1:0]  mem_data_o,
  output logic                           mem_data_ready_o,

  // word write port
  input  logic                           mem_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0]  mem_wr_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0]  mem_wr_data_i,
  input  logic [dcache_pkg::BE_W-1:0]    mem_wr_byte_en_i,
  output logic                           mem_wr_done_o
);
  import dcache_pkg::*;

  logic [DATA_W-1:0]                      mem_q [MEM_WORDS];

  // read side
  logic [ADDR_W-1:0]                      rd_addr_q;
  logic [MISS_PENALTY-1:0]                delay_q;
  logic [MEM_IDX_BITS-LINE_OFF_BITS-1:0]  rd_line_idx;

  // write side, word index wraps at the memory depth
  logic [MEM_IDX_BITS-1:0]                wr_word;

  assign rd_line_idx = rd_addr_q[WORD_OFF_BITS+LINE_OFF_BITS +: MEM_IDX_BITS-LINE_OFF_BITS];
  assign wr_word = mem_wr_addr_i[WORD_OFF_BITS +: MEM_IDX_BITS];

  // address held for the whole wait
  always_ff @(posedge clk)
  begin
    if (mem_re_i)
      rd_addr_q <= mem_addr_i;
  end

  // one-hot countdown
  // a new request starts at bit 0, walks up only on run cycles
  // top bit always drops after one cycle so ready stays a pulse
  always_ff @(posedge clk)
  begin
    if (reset)
      delay_q <= '0;
    else if (mem_re_i)
      delay_q <= {{(MISS_PENALTY-1){1'b0}}, 1'b1};
    else if (run_i)
      delay_q <= delay_q << 1;
    else
      delay_q[MISS_PENALTY-1] <= 1'b0;
  end

  assign mem_data_ready_o = delay_q[MISS_PENALTY-1];

  // line assembled straight from the array
  // stores landing during the wait show up here
  always_comb
  begin
    for (int w = 0; w < LINE_WORDS; w++)
      mem_data_o[w*DATA_W +: DATA_W] = mem_q[{rd_line_idx, LINE_OFF_BITS'(w)}];
  end

  // byte merge into the stored word
  always_ff @(posedge clk)
  begin
    if (mem_we_i)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (mem_wr_byte_en_i[b])
          mem_q[wr_word][b*BYTE_W +: BYTE_W] <= mem_wr_data_i[b*BYTE_W +: BYTE_W];
      end
    end
  end

  // done one cycle after the write
  always_ff @(posedge clk)
  begin
    if (reset)
      mem_wr_done_o <= 1'b0;
    else
      mem_wr_done_o <= mem_we_i;
  end

endmodule

// ==== hdl/dcache_subsys_top.sv ====
// dcache_subsys_top: L1 data cache controller and array over the L2 backing memory
`timescale 1ns/1ps

module dcache_subsys_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           run_i,
  input  logic                           req_valid_i,
  input  logic                           req_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0]  req_wdata_i,
  input  logic [dcache_pkg::BE_W-1:0]    req_be_i,
  output logic                           req_ready_o,
  output logic                           resp_valid_o,
  output logic [dcache_pkg::DATA_W-1:0]  resp_rdata_o
);
  import dcache_pkg::*;

  // controller to array
  logic                       arr_rd_en;
  logic [INDEX_BITS-1:0]      arr_index;
  logic                       arr_fill_en;
  logic [TAG_BITS-1:0]        arr_fill_tag;
  logic [LINE_W-1:0]          arr_fill_line;
  logic                       arr_upd_en;
  logic [LINE_OFF_BITS-1:0]   arr_upd_word;
  logic [DATA_W-1:0]          arr_upd_data;
  logic [BE_W-1:0]            arr_upd_be;
  logic [TAG_BITS-1:0]        arr_rd_tag;
  logic                       arr_rd_valid;
  logic [LINE_W-1:0]          arr_rd_line;

  // controller to backing memory
  logic                       mem_re;
  logic [ADDR_W-1:0]          mem_addr;
  logic                       mem_data_ready;
  logic [LINE_W-1:0]          mem_data;
  logic                       mem_we;
  logic [ADDR_W-1:0]          mem_wr_addr;
  logic [DATA_W-1:0]          mem_wr_data;
  logic [BE_W-1:0]            mem_wr_byte_en;
  logic                       mem_wr_done;

  dcache_ctrl u_ctrl (
    .clk              (clk),
    .reset            (reset),
    .req_valid_i      (req_valid_i),
    .req_we_i         (req_we_i),
    .req_addr_i       (req_addr_i),
    .req_wdata_i      (req_wdata_i),
    .req_be_i         (req_be_i),
    .req_ready_o      (req_ready_o),
    .resp_valid_o     (resp_valid_o),
    .resp_rdata_o     (resp_rdata_o),
    .arr_rd_en_o      (arr_rd_en),
    .arr_index_o      (arr_index),
    .arr_fill_en_o    (arr_fill_en),
    .arr_fill_tag_o   (arr_fill_tag),
    .arr_fill_line_o  (arr_fill_line),
    .arr_upd_en_o     (arr_upd_en),
    .arr_upd_word_o   (arr_upd_word),
    .arr_upd_data_o   (arr_upd_data),
    .arr_upd_be_o     (arr_upd_be),
    .arr_rd_tag_i     (arr_rd_tag),
    .arr_rd_valid_i   (arr_rd_valid),
    .arr_rd_line_i    (arr_rd_line),
    .mem_re_o         (mem_re),
    .mem_addr_o       (mem_addr),
    .mem_we_o         (mem_we),
    .mem_wr_addr_o    (mem_wr_addr),
    .mem_wr_data_o    (mem_wr_data),
    .mem_wr_byte_en_o (mem_wr_byte_en),
    .mem_data_ready_i (mem_data_ready),
    .mem_data_i       (mem_data),
    .mem_wr_done_i    (mem_wr_done)
  );

  dcache_array u_array (
    .clk          (clk),
    .reset        (reset),
    .rd_en_i      (arr_rd_en),
    .index_i      (arr_index),
    .fill_en_i    (arr_fill_en),
    .fill_tag_i   (arr_fill_tag),
    .fill_line_i  (arr_fill_line),
    .upd_en_i     (arr_upd_en),
    .upd_word_i   (arr_upd_word),
    .upd_data_i   (arr_upd_data),
    .upd_be_i     (arr_upd_be),
    .rd_tag_o     (arr_rd_tag),
    .rd_valid_o   (arr_rd_valid),
    .rd_line_o    (arr_rd_line)
  );

  // read latency taken from the package default
  l2_backing_mem #(
    .MISS_PENALTY (L2_MISS_PENALTY)
  ) u_l2 (
    .clk              (clk),
    .reset            (reset),
    .run_i            (run_i),
    .mem_re_i         (mem_re),
    .mem_addr_i       (mem_addr),
    .mem_data_o       (mem_data),
    .mem_data_ready_o (mem_data_ready),
    .mem_we_i         (mem_we),
    .mem_wr_addr_i    (mem_wr_addr),
    .mem_wr_data_i    (mem_wr_data),
    .mem_wr_byte_en_i (mem_wr_byte_en),
    .mem_wr_done_o    (mem_wr_done)
  );

endmodule

// ==== sim/dcache_subsys_chk.sv ====
// dcache_subsys_chk: CPU handshake assertions bound into the data cache subsystem top
`timescale 1ns/1ps

module dcache_subsys_chk (
  input  logic  clk,
  input  logic  reset,
  input  logic  req_valid_i,
  input  logic  req_ready_o,
  input  logic  resp_valid_o
);
  // request taken, response not yet seen
  logic outstanding_q;

  // failures per assertion
  int   pulse_fails;
  int   ready_fails;
  int   orphan_fails;
  int   reset_fails;
  int   fail_cnt;

  assign fail_cnt = pulse_fails + ready_fails + orphan_fails + reset_fails;

  // a new request can be taken in its predecessor's response cycle
  always_ff @(posedge clk)
  begin
    if (reset)
      outstanding_q <= 1'b0;
    else if (req_valid_i && req_ready_o)
      outstanding_q <= 1'b1;
    else if (resp_valid_o)
      outstanding_q <= 1'b0;
  end

  // response is a one-cycle pulse
  resp_pulse_a: assert property (@(posedge clk) disable iff (reset)
    resp_valid_o |=> !resp_valid_o)
  else
  begin
    pulse_fails++;
    $error("resp_valid_o high for two cycles in a row");
  end

  // no second request while one is in flight
  ready_busy_a: assert property (@(posedge clk) disable iff (reset)
    outstanding_q && !resp_valid_o |-> !req_ready_o)
  else
  begin
    ready_fails++;
    $error("req_ready_o high while a request is outstanding");
  end

  resp_orphan_a: assert property (@(posedge clk) disable iff (reset)
    resp_valid_o |-> outstanding_q)
  else
  begin
    orphan_fails++;
    $error("resp_valid_o without an accepted request");
  end

  // idle and quiet out of reset
  reset_idle_a: assert property (@(posedge clk)
    reset |=> req_ready_o && !resp_valid_o)
  else
  begin
    reset_fails++;
    $error("req_ready_o low or resp_valid_o high after reset");
  end

endmodule

bind dcache_subsys_top dcache_subsys_chk u_chk (
  .clk          (clk),
  .reset        (reset),
  .req_valid_i  (req_valid_i),
  .req_ready_o  (req_ready_o),
  .resp_valid_o (resp_valid_o)
);

// ==== sim/dcache_subsys_tb.sv ====
// dcache_subsys_tb drives the L1 data cache subsystem and checks loads against a shadow memory
`timescale 1ns/1ps

module dcache_subsys_tb;
  import dcache_pkg::*;

  localparam int RESET_CYCLES = 16;
  // request count of tests 1 to 6 in run order
  localparam int NUM_REQS = 128 + 36 + 48 + 16 + 7 + 12;
  localparam int TIMEOUT_CYCLES = 40 * NUM_REQS + RESET_CYCLES;
  // latencies in cycles from acceptance edge to response edge
  localparam int HIT_LAT = 2;
  localparam int MISS_LAT = L2_MISS_PENALTY + 3;
  localparam int STORE_LAT = 3;

  logic               clk;
  logic               reset;
  logic               run_i;
  logic               req_valid_i;
  logic               req_we_i;
  logic [ADDR_W-1:0]  req_addr_i;
  logic [DATA_W-1:0]  req_wdata_i;
  logic [BE_W-1:0]    req_be_i;
  logic               req_ready_o;
  logic               resp_valid_o;
  logic [DATA_W-1:0]  resp_rdata_o;

  // shadow of the backing memory
  logic [DATA_W-1:0]  shadow_mem [MEM_WORDS];
  logic [31:0]        lfsr_q;
  int                 cyc;
  int                 issue_cnt;
  int                 resp_cnt;
  int                 check_cnt;
  int                 data_errs;
  int                 lat_errs;
  int                 proto_errs;
  // expected latency of the request being driven or 0 to skip it
  int                 next_lat;

  // request in flight as captured at acceptance
  bit                 pend_valid;
  bit                 pend_we;
  logic [DATA_W-1:0]  pend_data;
  int                 pend_lat;
  int                 pend_cyc;
  int                 lat;

  dcache_subsys_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .run_i        (run_i),
    .req_valid_i  (req_valid_i),
    .req_we_i     (req_we_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  // galois form shifts right and folds the taps in on a one
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // word index wrapping at the memory depth
  function automatic logic [MEM_IDX_BITS-1:0] word_of(input logic [ADDR_W-1:0] addr);
    word_of = addr[WORD_OFF_BITS +: MEM_IDX_BITS];
  endfunction

  // expected load result
  function automatic logic [DATA_W-1:0] exp_load(input logic [ADDR_W-1:0] addr);
    exp_load = shadow_mem[word_of(addr)];
  endfunction

  // only enabled bytes change
  task automatic merge_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [BE_W-1:0] be);
    for (int b = 0; b < BE_W; b++)
    begin
      if (be[b])
        shadow_mem[word_of(addr)][b*BYTE_W +: BYTE_W] = data[b*BYTE_W +: BYTE_W];
    end
  endtask

  // drive one request until taken and wait for its response
  task automatic issue(input logic we, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be,
                       input int exp_lat, input int stall);
    next_lat = exp_lat;
    req_we_i = we;
    req_addr_i = addr;
    req_wdata_i = data;
    req_be_i = be;
    req_valid_i = 1'b1;
    issue_cnt++;
    @(negedge clk);
    while (!req_ready_o)
      @(negedge clk);
    @(posedge clk);
    #2;
    req_valid_i = 1'b0;
    // core halted after mem_re freezes the countdown
    if (stall > 0)
    begin
      repeat (2) @(posedge clk);
      #2;
      run_i = 1'b0;
      repeat (stall) @(posedge clk);
      #2;
      run_i = 1'b1;
    end
    do
      @(posedge clk);
    while (resp_cnt < issue_cnt);
    #2;
  endtask

  // compare sampled mid-cycle
  // response handled first since a new request may be taken in the same cycle
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (resp_valid_o)
      begin
        resp_cnt++;
        if (!pend_valid)
        begin
          proto_errs++;
          $display("response at %0d ns with no accepted request", $time);
        end
        else
        begin
          lat = cyc - pend_cyc;
          if (!pend_we)
          begin
            check_cnt++;
            if (resp_rdata_o !== pend_data)
            begin
              data_errs++;
              $display("CHECK FAILED at %0d ns: resp_rdata_o = %h, expected %h",
                       $time, resp_rdata_o, pend_data);
            end
          end
          if (pend_lat != 0)
          begin
            check_cnt++;
            if (lat != pend_lat)
            begin
              lat_errs++;
              $display("CHECK FAILED at %0d ns: resp_valid_o latency = %0d, expected %0d",
                       $time, lat, pend_lat);
            end
          end
          pend_valid = 1'b0;
        end
      end
      if (req_valid_i && req_ready_o)
      begin
        pend_valid = 1'b1;
        pend_we = req_we_i;
        pend_lat = next_lat;
        pend_cyc = cyc;
        pend_data = '0;
        if (req_we_i)
          merge_store(req_addr_i, req_wdata_i, req_be_i);
        else
          pend_data = exp_load(req_addr_i);
      end
    end
  end

  initial
  begin
    while (cyc < TIMEOUT_CYCLES)
      @(posedge clk);
    $display("timeout: no progress after %0d cycles, %0d of %0d responses",
             cyc, resp_cnt, issue_cnt);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] r;
    logic [31:0] d;
    int          w;
    int          k;
    int          total;

    reset = 1'b1;
    run_i = 1'b1;
    req_valid_i = 1'b0;
    req_we_i = 1'b0;
    req_addr_i = '0;
    req_wdata_i = '0;
    req_be_i = '0;
    lfsr_q = 32'd38;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;

    // test 1 stores 64 full words and reads every word back
    for (int i = 0; i < 64; i++)
    begin
      take_bits(32, d);
      issue(1'b1, ADDR_W'(i * 4), d, '1, STORE_LAT, 0);
    end
    for (int i = 0; i < 64; i++)
      issue(1'b0, ADDR_W'(i * 4), '0, '0, 0, 0);

    // test 2 puts a second tag over sets 0 to 3 with one miss then hits per line
    for (int i = 64; i < 80; i++)
    begin
      take_bits(32, d);
      issue(1'b1, ADDR_W'(i * 4), d, '1, STORE_LAT, 0);
    end
    for (int ln = 0; ln < 4; ln++)
    begin
      issue(1'b0, ADDR_W'(256 + ln * 16), '0, '0, MISS_LAT, 0);
      for (int wd = 1; wd < 4; wd++)
        issue(1'b0, ADDR_W'(256 + ln * 16 + wd * 4), '0, '0, HIT_LAT, 0);
      issue(1'b0, ADDR_W'(256 + ln * 16), '0, '0, HIT_LAT, 0);
    end

    // test 3 does partial stores over both regions whether cached or not
    for (int i = 0; i < 16; i++)
    begin
      take_bits(7, r);
      w = int'(r % 80);
      take_bits(32, d);
      take_bits(4, r);
      issue(1'b1, ADDR_W'(w * 4), d, r[BE_W-1:0], STORE_LAT, 0);
      issue(1'b0, ADDR_W'(w * 4), '0, '0, 0, 0);
      take_bits(7, r);
      w = int'(r % 80);
      issue(1'b0, ADDR_W'(w * 4), '0, '0, 0, 0);
    end

    // test 4 alternates two tags in one set so every load after the first evicts
    for (int i = 0; i < 8; i++)
    begin
      issue(1'b0, ADDR_W'('h014), '0, '0, (i == 0) ? 0 : MISS_LAT, 0);
      issue(1'b0, ADDR_W'('h114), '0, '0, MISS_LAT, 0);
    end

    // test 5 misses in set 2 with the core halted mid-wait
    issue(1'b0, ADDR_W'('h128), '0, '0, 0, 0);
    for (int i = 0; i < 6; i++)
    begin
      take_bits(3, r);
      k = int'(r) + 1;
      w = (i % 2 == 0) ? 'h028 : 'h128;
      issue(1'b0, ADDR_W'(w), '0, '0, MISS_LAT + k, k);
    end

    // test 6 loads right after a store hit and must see the new bytes
    for (int i = 0; i < 4; i++)
    begin
      issue(1'b0, ADDR_W'('h050 + i * 4), '0, '0, 0, 0);
      take_bits(32, d);
      take_bits(4, r);
      issue(1'b1, ADDR_W'('h050 + i * 4), d, r[BE_W-1:0], STORE_LAT, 0);
      issue(1'b0, ADDR_W'('h050 + i * 4), '0, '0, HIT_LAT, 0);
    end

    repeat (2) @(posedge clk);
    total = data_errs + lat_errs + proto_errs + u_dut.u_chk.fail_cnt;
    $display("requests %0d, checks %0d, errors data %0d latency %0d other %0d asserts %0d",
             issue_cnt, check_cnt, data_errs, lat_errs, proto_errs, u_dut.u_chk.fail_cnt);
    if (total == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
common/dcache_pkg.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
hdl/l2_backing_mem.sv
hdl/dcache_subsys_top.sv
sim/dcache_subsys_chk.sv
sim/dcache_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run of the data cache subsystem testbench

VERILATOR ?= verilator
TOP       ?= dcache_subsys_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)

# fails on a bad exit status, on the fail message, or with no pass message
run: $(SIM_BIN)
	@./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG) || \
	   ! grep -q "TEST PASSED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
